// File: verilog/vae_fixed_pkg.sv
// Q16.16 fixed-point types and arithmetic used by the VAE datapath and the testbench model
`default_nettype none

package vae_fixed_pkg;

    // Signed Q16.16
    typedef logic signed [31:0] fixed_t;

    // Reconstructed pixel in Q8.8
    typedef logic [15:0] recon_pix_t;

    localparam int FRAC_BITS = 16;

    localparam fixed_t FX_ONE    = 32'sh0001_0000;
    localparam fixed_t RELU_CEIL = 32'sh0010_0000;

    // Full-width product, then back to Q16.16
    function automatic fixed_t fx_mul(input fixed_t a, input fixed_t b);
        logic signed [63:0] full;
        full = a * b;
        return fixed_t'(full >>> FRAC_BITS);
    endfunction

    // ReLU with an upper limit of 16.0
    function automatic fixed_t fx_relu(input fixed_t v);
        if (v < 0) begin
            return '0;
        end
        if (v > RELU_CEIL) begin
            return RELU_CEIL;
        end
        return v;
    endfunction

    // Round to Q8.8, input is already clamped to [0, 16.0]
    function automatic recon_pix_t fx_to_recon(input fixed_t v);
        recon_pix_t rounded;
        rounded = v[FRAC_BITS+7:FRAC_BITS-8] + recon_pix_t'(v[FRAC_BITS-9]);
        return rounded;
    endfunction

endpackage

`default_nettype wire

// File: verilog/vae_net_pkg.sv
// Network shape, weight address map and port structs of the VAE reconstruction core
`default_nettype none

package vae_net_pkg;

    // Network dimensions
    localparam int N_PIX = 9;
    localparam int N_LAT = 2;

    // Serial input index widths of the two layers
    localparam int ENC_IDX_W = $clog2(N_PIX);
    localparam int DEC_IDX_W = $clog2(N_LAT);

    localparam int CFG_ADDR_W = 6;

    // Bit k is pixel k+1, row-major
    typedef logic [N_PIX-1:0] pattern_t;

    typedef vae_fixed_pkg::recon_pix_t [N_PIX-1:0] recon_t;

    // Single-entry parameter write
    typedef struct packed {
        logic                   wr;
        logic [CFG_ADDR_W-1:0]  addr;
        vae_fixed_pkg::fixed_t  data;
    } cfg_wr_t;

    // Address map
    // Encoder weight n*N_PIX+k, decoder weight m*N_LAT+n
    localparam int ADDR_ENC_W    = 0;
    localparam int ADDR_ENC_B    = ADDR_ENC_W + N_LAT * N_PIX;
    localparam int ADDR_DEC_W    = ADDR_ENC_B + N_LAT;
    localparam int ADDR_DEC_B    = ADDR_DEC_W + N_PIX * N_LAT;
    localparam int N_CFG_ENTRIES = ADDR_DEC_B + N_PIX;

    // Power-up values of the untrained network
    localparam vae_fixed_pkg::fixed_t ENC_W0_INIT = 32'sh0000_8000;
    localparam vae_fixed_pkg::fixed_t W_INIT      = 32'sh0000_2000;
    localparam vae_fixed_pkg::fixed_t B_INIT      = 32'sh0000_1966;

endpackage

`default_nettype wire

// File: verilog/vae_weight_regs.sv
// Register block for all encoder and decoder weights and biases, written one entry at a time
`timescale 1ns/1ps
`default_nettype none

module vae_weight_regs (
    input  logic                                                      clk,
    input  logic                                                      rst,
    input  vae_net_pkg::cfg_wr_t                                      cfg,
    input  logic                                                      busy,
    output vae_fixed_pkg::fixed_t [vae_net_pkg::N_LAT-1:0][vae_net_pkg::N_PIX-1:0] enc_w,
    output vae_fixed_pkg::fixed_t [vae_net_pkg::N_LAT-1:0]            enc_b,
    output vae_fixed_pkg::fixed_t [vae_net_pkg::N_PIX-1:0][vae_net_pkg::N_LAT-1:0] dec_w,
    output vae_fixed_pkg::fixed_t [vae_net_pkg::N_PIX-1:0]            dec_b
);
    import vae_fixed_pkg::*;
    import vae_net_pkg::*;

    fixed_t [N_CFG_ENTRIES-1:0] cfg_q;
    logic                       wr_ok;

    // Reset value of each entry
    function automatic fixed_t entry_default(input int a);
        if (a < ADDR_ENC_W + N_PIX) begin
            return ENC_W0_INIT;
        end
        if (a < ADDR_ENC_B) begin
            return W_INIT;
        end
        if (a < ADDR_DEC_W) begin
            return B_INIT;
        end
        if (a < ADDR_DEC_B) begin
            return W_INIT;
        end
        return B_INIT;
    endfunction

    // Writes only between inferences and inside the map
    assign wr_ok = cfg.wr && !busy && (int'(cfg.addr) < N_CFG_ENTRIES);

    always_ff @(posedge clk) begin
        if (rst) begin
            for (int a = 0; a < N_CFG_ENTRIES; a++) begin
                cfg_q[a] <= entry_default(a);
            end
        end else if (wr_ok) begin
            cfg_q[cfg.addr] <= cfg.data;
        end
    end

    // Encoder side
    for (genvar n = 0; n < N_LAT; n++) begin : g_enc
        for (genvar k = 0; k < N_PIX; k++) begin : g_pix
            assign enc_w[n][k] = cfg_q[ADDR_ENC_W + n * N_PIX + k];
        end
        assign enc_b[n] = cfg_q[ADDR_ENC_B + n];
    end

    // Decoder side
    for (genvar m = 0; m < N_PIX; m++) begin : g_dec
        for (genvar n = 0; n < N_LAT; n++) begin : g_lat
            assign dec_w[m][n] = cfg_q[ADDR_DEC_W + m * N_LAT + n];
        end
        assign dec_b[m] = cfg_q[ADDR_DEC_B + m];
    end

    // Weights must hold still while the layers read them
    a_stable_while_busy: assert property (
        @(posedge clk) (busy && !rst) |=> $stable(cfg_q)
    );

endmodule

`default_nettype wire

// File: verilog/vae_dense_layer.sv
// Serial fully connected layer with bias and clamped ReLU, one input consumed per clock
`timescale 1ns/1ps
`default_nettype none

module vae_dense_layer #(
    parameter int N_IN  = 9,
    parameter int N_OUT = 2
) (
    input  logic                                            clk,
    input  logic                                            rst,
    input  logic                                            start,
    input  vae_fixed_pkg::fixed_t                           x,
    input  vae_fixed_pkg::fixed_t [N_OUT-1:0][N_IN-1:0]     w,
    input  vae_fixed_pkg::fixed_t [N_OUT-1:0]               b,
    output logic [$clog2(N_IN > 1 ? N_IN : 2)-1:0]          x_idx,
    output vae_fixed_pkg::fixed_t [N_OUT-1:0]               y,
    output logic                                            done
);
    import vae_fixed_pkg::*;

    localparam int IDX_W = $clog2(N_IN > 1 ? N_IN : 2);

    logic [IDX_W-1:0]   cnt;
    logic               run;
    logic               last;
    fixed_t [N_OUT-1:0] acc;
    fixed_t [N_OUT-1:0] prod;
    fixed_t [N_OUT-1:0] sum;

    assign x_idx = cnt;
    assign last  = run && (cnt == IDX_W'(N_IN - 1));

    // Input counter
    always_ff @(posedge clk) begin
        if (rst) begin
            cnt  <= '0;
            run  <= 1'b0;
            done <= 1'b0;
        end else begin
            done <= last;
            if (start) begin
                cnt <= '0;
                run <= 1'b1;
            end else if (last) begin
                cnt <= '0;
                run <= 1'b0;
            end else if (run) begin
                cnt <= cnt + 1'b1;
            end
        end
    end

    // Each neuron picks its own weight for the current input
    always_comb begin
        for (int n = 0; n < N_OUT; n++) begin
            prod[n] = fx_mul(x, w[n][cnt]);
            sum[n]  = acc[n] + prod[n];
        end
    end

    // Last step folds in the bias and activation directly
    always_ff @(posedge clk) begin
        for (int n = 0; n < N_OUT; n++) begin
            if (start) begin
                acc[n] <= '0;
            end else if (run) begin
                acc[n] <= sum[n];
            end
            if (last) begin
                y[n] <= fx_relu(sum[n] + b[n]);
            end
        end
    end

    // Sequencer never restarts a layer mid-pass
    a_no_restart: assert property (
        @(posedge clk) disable iff (rst) start |-> !run
    );

endmodule

`default_nettype wire

// File: verilog/vae_infer_ctrl.sv
// Inference sequencer: captures a pattern, runs encoder then decoder, rounds the reconstruction
`timescale 1ns/1ps
`default_nettype none

module vae_infer_ctrl (
    input  logic                                        clk,
    input  logic                                        rst,
    input  logic                                        start,
    input  vae_net_pkg::pattern_t                       pattern,
    input  logic [vae_net_pkg::ENC_IDX_W-1:0]           enc_idx,
    input  vae_fixed_pkg::fixed_t [vae_net_pkg::N_LAT-1:0] enc_y,
    input  logic                                        enc_done,
    input  logic [vae_net_pkg::DEC_IDX_W-1:0]           dec_idx,
    input  logic                                        dec_done,
    input  vae_fixed_pkg::fixed_t [vae_net_pkg::N_PIX-1:0] dec_y,
    output logic                                        enc_start,
    output vae_fixed_pkg::fixed_t                       enc_x,
    output logic                                        dec_start,
    output vae_fixed_pkg::fixed_t                       dec_x,
    output logic                                        busy,
    output logic                                        recon_valid,
    output vae_net_pkg::recon_t                         recon
);
    import vae_fixed_pkg::*;
    import vae_net_pkg::*;

    logic               accept;
    pattern_t           pat_q;
    fixed_t [N_LAT-1:0] lat_q;
    recon_t             recon_d;

    assign accept = start && !busy;

    // Binary pixel to 1.0 or 0.0
    assign enc_x = pat_q[enc_idx] ? FX_ONE : '0;

    // Latent mean feeds the decoder directly
    assign dec_x = lat_q[dec_idx];

    always_comb begin
        for (int m = 0; m < N_PIX; m++) begin
            recon_d[m] = fx_to_recon(dec_y[m]);
        end
    end

    // Busy spans the whole pass including the result cycle
    always_ff @(posedge clk) begin
        if (rst) begin
            busy        <= 1'b0;
            enc_start   <= 1'b0;
            dec_start   <= 1'b0;
            recon_valid <= 1'b0;
            recon       <= '0;
        end else begin
            enc_start   <= accept;
            dec_start   <= enc_done;
            recon_valid <= dec_done;
            if (accept) begin
                busy <= 1'b1;
            end else if (recon_valid) begin
                busy <= 1'b0;
            end
            if (dec_done) begin
                recon <= recon_d;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (accept) begin
            pat_q <= pattern;
        end
        if (enc_done) begin
            lat_q <= enc_y;
        end
    end

    // Result only appears inside the busy window
    a_valid_in_busy: assert property (
        @(posedge clk) disable iff (rst) recon_valid |-> busy
    );

endmodule

`default_nettype wire

// File: verilog/vae_recon_top.sv
// Top level of the VAE reconstruction core: weight registers, sequencer and two dense layers
`timescale 1ns/1ps
`default_nettype none

module vae_recon_top (
    input  logic                    clk,
    input  logic                    rst,
    input  logic                    start,
    input  vae_net_pkg::pattern_t   pattern,
    input  vae_net_pkg::cfg_wr_t    cfg,
    output logic                    busy,
    output logic                    recon_valid,
    output vae_net_pkg::recon_t     recon
);
    import vae_fixed_pkg::*;
    import vae_net_pkg::*;

    fixed_t [N_LAT-1:0][N_PIX-1:0] enc_w;
    fixed_t [N_LAT-1:0]            enc_b;
    fixed_t [N_PIX-1:0][N_LAT-1:0] dec_w;
    fixed_t [N_PIX-1:0]            dec_b;

    logic                 enc_start;
    logic                 enc_done;
    logic [ENC_IDX_W-1:0] enc_idx;
    fixed_t               enc_x;
    fixed_t [N_LAT-1:0]   enc_y;

    logic                 dec_start;
    logic                 dec_done;
    logic [DEC_IDX_W-1:0] dec_idx;
    fixed_t               dec_x;
    fixed_t [N_PIX-1:0]   dec_y;

    vae_weight_regs u_weight_regs (
        .clk   (clk),
        .rst   (rst),
        .cfg   (cfg),
        .busy  (busy),
        .enc_w (enc_w),
        .enc_b (enc_b),
        .dec_w (dec_w),
        .dec_b (dec_b)
    );

    vae_infer_ctrl u_ctrl (
        .clk         (clk),
        .rst         (rst),
        .start       (start),
        .pattern     (pattern),
        .enc_idx     (enc_idx),
        .enc_y       (enc_y),
        .enc_done    (enc_done),
        .dec_idx     (dec_idx),
        .dec_done    (dec_done),
        .dec_y       (dec_y),
        .enc_start   (enc_start),
        .enc_x       (enc_x),
        .dec_start   (dec_start),
        .dec_x       (dec_x),
        .busy        (busy),
        .recon_valid (recon_valid),
        .recon       (recon)
    );

    // Encoder mean layer
    vae_dense_layer #(.N_IN(N_PIX), .N_OUT(N_LAT)) u_encoder (
        .clk   (clk),
        .rst   (rst),
        .start (enc_start),
        .x     (enc_x),
        .w     (enc_w),
        .b     (enc_b),
        .x_idx (enc_idx),
        .y     (enc_y),
        .done  (enc_done)
    );

    vae_dense_layer #(.N_IN(N_LAT), .N_OUT(N_PIX)) u_decoder (
        .clk   (clk),
        .rst   (rst),
        .start (dec_start),
        .x     (dec_x),
        .w     (dec_w),
        .b     (dec_b),
        .x_idx (dec_idx),
        .y     (dec_y),
        .done  (dec_done)
    );

endmodule

`default_nettype wire

// File: testbench/vae_recon_model.svh
// Reference model of the VAE core, included inside the testbench module after the package imports
`ifndef VAE_RECON_MODEL_SVH
`define VAE_RECON_MODEL_SVH

    // Shadow copy of every parameter entry
    fixed_t shadow_cfg [N_CFG_ENTRIES];

    function automatic void model_reset();
        for (int a = 0; a < N_CFG_ENTRIES; a++) begin
            if (a < ADDR_ENC_W + N_PIX) begin
                shadow_cfg[a] = ENC_W0_INIT;
            end else if (a < ADDR_ENC_B || (a >= ADDR_DEC_W && a < ADDR_DEC_B)) begin
                shadow_cfg[a] = W_INIT;
            end else begin
                shadow_cfg[a] = B_INIT;
            end
        end
    endfunction

    // Out-of-map addresses are dropped by the hardware
    function automatic void model_write(input int a, input fixed_t d);
        if (a >= 0 && a < N_CFG_ENTRIES) begin
            shadow_cfg[a] = d;
        end
    endfunction

    function automatic recon_t model_recon(input pattern_t p);
        fixed_t lat [N_LAT];
        fixed_t acc;
        fixed_t x;
        recon_t r;
        // Encoder mean, pixels in index order
        for (int n = 0; n < N_LAT; n++) begin
            acc = '0;
            for (int k = 0; k < N_PIX; k++) begin
                x = p[k] ? FX_ONE : '0;
                acc = acc + fx_mul(x, shadow_cfg[ADDR_ENC_W + n * N_PIX + k]);
            end
            lat[n] = fx_relu(acc + shadow_cfg[ADDR_ENC_B + n]);
        end
        // Decoder, then rounding to Q8.8
        for (int m = 0; m < N_PIX; m++) begin
            acc = '0;
            for (int n = 0; n < N_LAT; n++) begin
                acc = acc + fx_mul(lat[n], shadow_cfg[ADDR_DEC_W + m * N_LAT + n]);
            end
            r[m] = fx_to_recon(fx_relu(acc + shadow_cfg[ADDR_DEC_B + m]));
        end
        return r;
    endfunction

`endif

// File: testbench/vae_recon_tb.sv
// Directed testbench for the VAE reconstruction core, compiled from the file list by the sim script
`timescale 1ns/1ps
`default_nettype none

module vae_recon_tb;
    import vae_fixed_pkg::*;
    import vae_net_pkg::*;

    localparam int       TIMEOUT_CYCLES = 40;
    localparam pattern_t PAT_O = 9'b111_101_111;
    localparam pattern_t PAT_X = 9'b101_010_101;

    logic     clk;
    logic     rst;
    logic     start;
    pattern_t pattern;
    cfg_wr_t  cfg;
    logic     busy;
    logic     recon_valid;
    recon_t   recon;

    int     mismatches = 0;
    int     timeouts = 0;
    integer seed;

    `include "vae_recon_model.svh"

    vae_recon_top dut (
        .clk         (clk),
        .rst         (rst),
        .start       (start),
        .pattern     (pattern),
        .cfg         (cfg),
        .busy        (busy),
        .recon_valid (recon_valid),
        .recon       (recon)
    );

    initial begin
        clk = 1'b0;
        forever #4 clk = ~clk;
    end

    task automatic check_recon(input recon_t got, input recon_t exp, input string msg);
        if (got !== exp) begin
            mismatches++;
            $display("Mismatch at time %0t: %s, recon %h, expected %h", $time, msg, got, exp);
        end
    endtask

    task automatic check_bit(input logic got, input logic exp, input string msg);
        if (got !== exp) begin
            mismatches++;
            $display("Mismatch at time %0t: %s is %b, expected %b", $time, msg, got, exp);
        end
    endtask

    task automatic finish_run();
        $display("Errors: %0d mismatches, %0d timeouts", mismatches, timeouts);
        if (mismatches == 0 && timeouts == 0) begin
            $display("All checks passed");
        end else begin
            $display("Checks failed");
        end
        $finish;
    endtask

    // Takes effect at the following edge
    task automatic write_entry(input int a, input fixed_t d);
        @(posedge clk);
        cfg <= '{wr: 1'b1, addr: CFG_ADDR_W'(a), data: d};
        model_write(a, d);
    endtask

    task automatic run_pattern(input pattern_t p, output recon_t got);
        int cycles;
        @(posedge clk);
        start   <= 1'b1;
        pattern <= p;
        cfg.wr  <= 1'b0;
        @(posedge clk);
        start <= 1'b0;
        cycles = 0;
        while (recon_valid !== 1'b1 && cycles < TIMEOUT_CYCLES) begin
            @(negedge clk);
            cycles++;
        end
        if (recon_valid !== 1'b1) begin
            timeouts++;
            $display("Timed out after %0d cycles waiting for recon_valid", cycles);
        end
        got = recon;
    endtask

    task automatic run_and_check(input pattern_t p, input string msg);
        recon_t got;
        run_pattern(p, got);
        check_recon(got, model_recon(p), msg);
    endtask

    task automatic test_reset_defaults();
        @(negedge clk);
        check_bit(busy, 1'b0, "busy after reset");
        check_bit(recon_valid, 1'b0, "recon_valid after reset");
        check_recon(recon, '0, "recon after reset");
        run_and_check(PAT_O, "O pattern with default weights");
    endtask

    // Cycle c is the interval after edge c-1 and edge 0 samples start
    task automatic test_timing();
        recon_t exp;
        exp = model_recon(PAT_X);
        @(posedge clk);
        start   <= 1'b1;
        pattern <= PAT_X;
        cfg.wr  <= 1'b0;
        @(posedge clk);
        start <= 1'b0;
        for (int c = 1; c <= 24; c++) begin
            @(negedge clk);
            check_bit(busy, c <= 16, $sformatf("busy in cycle %0d", c));
            check_bit(recon_valid, c == 16, $sformatf("recon_valid in cycle %0d", c));
            if (c >= 16) begin
                check_recon(recon, exp, $sformatf("recon in cycle %0d", c));
            end
            if (c == 4) begin
                @(posedge clk);
                start   <= 1'b1;
                pattern <= PAT_O;
                cfg     <= '{wr: 1'b1, addr: CFG_ADDR_W'(ADDR_DEC_B), data: RELU_CEIL};
            end else if (c == 5) begin
                @(posedge clk);
                start  <= 1'b0;
                cfg.wr <= 1'b0;
            end
        end
        run_and_check(PAT_X, "X pattern after write during busy");
    endtask

    task automatic test_weight_programming();
        for (int a = 0; a < N_CFG_ENTRIES; a++) begin
            write_entry(a, fixed_t'(((a * 7) % 11 - 5) * 6144));
        end
        write_entry(63, RELU_CEIL);
        run_and_check(PAT_X, "X pattern with programmed weights");
    endtask

    task automatic test_clamping();
        recon_t got;
        recon_t ceil_all;
        for (int m = 0; m < N_PIX; m++) begin
            ceil_all[m] = 16'h1000;
        end
        // 4.0 weights, zero biases
        for (int a = 0; a < N_CFG_ENTRIES; a++) begin
            if (a < ADDR_ENC_B || (a >= ADDR_DEC_W && a < ADDR_DEC_B)) begin
                write_entry(a, 32'sh0004_0000);
            end else begin
                write_entry(a, '0);
            end
        end
        run_pattern(PAT_X, got);
        check_recon(got, ceil_all, "outputs at ceiling");
        check_recon(got, model_recon(PAT_X), "ceiling against model");
        // Decoder weights -2.0, biases -1.0
        for (int a = ADDR_DEC_W; a < N_CFG_ENTRIES; a++) begin
            write_entry(a, (a < ADDR_DEC_B) ? 32'shFFFE_0000 : 32'shFFFF_0000);
        end
        run_pattern(PAT_X, got);
        check_recon(got, '0, "outputs clamped to zero");
        check_recon(got, model_recon(PAT_X), "zero clamp against model");
    endtask

    task automatic test_random_sweep();
        pattern_t p;
        for (int i = 0; i < 24; i++) begin
            for (int a = 0; a < N_CFG_ENTRIES; a++) begin
                write_entry(a, fixed_t'($random(seed) % 65536));
            end
            p = pattern_t'($random(seed));
            run_and_check(p, $sformatf("random sweep %0d", i));
        end
    endtask

    initial begin
        rst     = 1'b1;
        start   = 1'b0;
        pattern = '0;
        cfg     = '0;
        seed    = 32'ha544;
        model_reset();
        repeat (16) @(posedge clk);
        rst <= 1'b0;
        test_reset_defaults();
        test_timing();
        test_weight_programming();
        test_clamping();
        test_random_sweep();
        finish_run();
    end

endmodule

`default_nettype wire

// File: vae_recon.f
+incdir+testbench
verilog/vae_fixed_pkg.sv
verilog/vae_net_pkg.sv
verilog/vae_weight_regs.sv
verilog/vae_dense_layer.sv
verilog/vae_infer_ctrl.sv
verilog/vae_recon_top.sv
testbench/vae_recon_tb.sv

// File: run_sim.sh
#!/bin/sh
# Builds the testbench with Verilator, runs it and scans the log for failure
cd "$(dirname "$0")" || exit 1
rm -f sim.log
verilator --binary --timing --assert -Wno-fatal -f vae_recon.f --top-module vae_recon_tb \
    -Mdir obj_dir \
    && ./obj_dir/Vvae_recon_tb > sim.log 2>&1 \
    || { cat sim.log 2>/dev/null; echo "Build or simulation run failed"; exit 1; }
cat sim.log
grep -q "Checks failed" sim.log && { echo "Simulation reported failure"; exit 1; } \
    || { echo "Simulation finished without failure"; exit 0; }
